/* design/fir_channel.sv */
`timescale 1ns/1ps

module fir_channel import fir_pkg::*; #(
    parameter  int data_width = 9,
    localparam int mult_width = data_width + COEFF_WIDTH + 1,
    localparam int acc_width  = mult_width + ACC_GROWTH
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          load,
    input  logic                          clear,
    input  logic                          step,
    input  logic                          centre,
    input  logic [HIST_ADDR_WIDTH-1:0]    wr_addr,
    input  logic [HIST_ADDR_WIDTH-1:0]    fwd_addr,
    input  logic [HIST_ADDR_WIDTH-1:0]    rev_addr,
    input  logic signed [COEFF_WIDTH-1:0] coeff,
    input  logic signed [data_width-1:0]  sample_in,
    output logic signed [acc_width-1:0]   acc
);

    logic signed [data_width-1:0] hist [HIST_DEPTH];

    logic signed [data_width-1:0] fwd_sample;
    logic signed [data_width-1:0] rev_sample;
    logic signed [data_width:0]   pre_sum;
    logic signed [mult_width-1:0] product;

    // History buffer write. A load with centre set, or any load while
    // rst is high, belongs to the clear sweep and stores zero.
    always_ff @(posedge clk) begin
        if (load) begin
            if (rst || centre) begin
                hist[wr_addr] <= '0;
            end else begin
                hist[wr_addr] <= sample_in;
            end
        end
    end

    assign fwd_sample = hist[fwd_addr];
    assign rev_sample = hist[rev_addr];

    // Fold the symmetric pair into one operand. The centre tap has no
    // partner, so only the forward sample is taken there.
    always_comb begin
        if (centre) begin
            pre_sum = fwd_sample;
        end else begin
            pre_sum = fwd_sample + rev_sample;
        end
    end

    assign product = pre_sum * coeff;

    always_ff @(posedge clk) begin
        if (rst) begin
            acc <= '0;
        end else if (clear) begin
            acc <= '0;
        end else if (step) begin
            acc <= acc + product;
        end
    end

endmodule

/* design/fir_coeff.svh */
`ifndef FIR_COEFF_SVH
`define FIR_COEFF_SVH

// Low-pass half filter, outermost tap first and centre tap last.
case (k)
    0:  return COEFF_WIDTH'(0);
    1:  return COEFF_WIDTH'(-1);
    2:  return COEFF_WIDTH'(-1);
    3:  return COEFF_WIDTH'(-2);
    4:  return COEFF_WIDTH'(-3);
    5:  return COEFF_WIDTH'(-3);
    6:  return COEFF_WIDTH'(-4);
    7:  return COEFF_WIDTH'(-4);
    8:  return COEFF_WIDTH'(-3);
    9:  return COEFF_WIDTH'(-1);
    10: return COEFF_WIDTH'(1);
    11: return COEFF_WIDTH'(3);
    12: return COEFF_WIDTH'(7);
    13: return COEFF_WIDTH'(10);
    14: return COEFF_WIDTH'(12);
    15: return COEFF_WIDTH'(13);
    16: return COEFF_WIDTH'(12);
    17: return COEFF_WIDTH'(9);
    18: return COEFF_WIDTH'(3);
    19: return COEFF_WIDTH'(-5);
    20: return COEFF_WIDTH'(-14);
    21: return COEFF_WIDTH'(-24);
    22: return COEFF_WIDTH'(-33);
    23: return COEFF_WIDTH'(-40);
    24: return COEFF_WIDTH'(-43);
    25: return COEFF_WIDTH'(-39);
    26: return COEFF_WIDTH'(-29);
    27: return COEFF_WIDTH'(-12);
    28: return COEFF_WIDTH'(13);
    29: return COEFF_WIDTH'(44);
    30: return COEFF_WIDTH'(80);
    31: return COEFF_WIDTH'(119);
    32: return COEFF_WIDTH'(157);
    33: return COEFF_WIDTH'(192);
    34: return COEFF_WIDTH'(222);
    35: return COEFF_WIDTH'(243);
    36: return COEFF_WIDTH'(255);
    default: return COEFF_WIDTH'(0);
endcase

`endif

/* design/fir_control.sv */
`timescale 1ns/1ps

module fir_control import fir_pkg::*; (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              sample,
    output logic                              load,
    output logic                              clear,
    output logic                              step,
    output logic                              centre,
    output logic                              finish,
    output logic [HIST_ADDR_WIDTH-1:0]        wr_addr,
    output logic [HIST_ADDR_WIDTH-1:0]        fwd_addr,
    output logic [HIST_ADDR_WIDTH-1:0]        rev_addr,
    output logic signed [COEFF_WIDTH-1:0]     coeff
);

    localparam int cnt_width = $clog2(FIR_HALF + 1);

    ctl_state_t state;

    logic sample_q;
    logic edge_q;
    logic sweeping;

    logic [cnt_width-1:0]       tap_cnt;
    logic [HIST_ADDR_WIDTH-1:0] wr_ptr;
    logic [HIST_ADDR_WIDTH-1:0] fwd_ptr;
    logic [HIST_ADDR_WIDTH-1:0] rev_ptr;

    // The strobe edge shows up one cycle after sample is first seen high.
    always_ff @(posedge clk) begin
        if (rst) begin
            sample_q <= 1'b0;
            edge_q   <= 1'b0;
        end else begin
            sample_q <= sample;
            edge_q   <= sample & ~sample_q;
        end
    end

    // The write pointer moves down by one per accepted sample, so the
    // sample k steps old sits at the newest address plus k.
    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= IDLE;
            sweeping <= 1'b1;
            wr_ptr   <= '0;
            tap_cnt  <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (sweeping) begin
                        // Clear one history entry per cycle after reset.
                        wr_ptr <= wr_ptr + 1'b1;
                        if (wr_ptr == HIST_ADDR_WIDTH'(HIST_DEPTH - 1)) begin
                            sweeping <= 1'b0;
                        end
                    end else if (edge_q) begin
                        wr_ptr  <= wr_ptr - 1'b1;
                        fwd_ptr <= wr_ptr - 1'b1;
                        rev_ptr <= (wr_ptr - 1'b1) + HIST_ADDR_WIDTH'(FIR_TAPS - 1);
                        state   <= LOAD;
                    end
                end
                LOAD: begin
                    tap_cnt <= '0;
                    state   <= MAC;
                end
                MAC: begin
                    // The two read pointers walk toward the centre tap.
                    fwd_ptr <= fwd_ptr + 1'b1;
                    rev_ptr <= rev_ptr - 1'b1;
                    tap_cnt <= tap_cnt + 1'b1;
                    if (tap_cnt == cnt_width'(FIR_HALF)) begin
                        state <= FINISH;
                    end
                end
                FINISH: begin
                    state <= IDLE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    assign load   = sweeping || (state == LOAD);
    assign clear  = (state == LOAD);
    assign step   = (state == MAC);
    assign finish = (state == FINISH);

    // During the sweep centre rides along with load, which makes the
    // channels write zero instead of the input samples.
    assign centre = sweeping || ((state == MAC) && (tap_cnt == cnt_width'(FIR_HALF)));

    assign wr_addr  = wr_ptr;
    assign fwd_addr = fwd_ptr;
    assign rev_addr = rev_ptr;
    assign coeff    = fir_coeff(int'(tap_cnt));

endmodule

/* design/fir_pkg.sv */
package fir_pkg;

    // Filter geometry. The filter is symmetric, so only half of the
    // coefficients plus the centre tap are stored.
    localparam int FIR_TAPS = 73;
    localparam int FIR_HALF = (FIR_TAPS - 1) / 2;

    // Signed coefficient width. The largest value is the centre tap, 255.
    localparam int COEFF_WIDTH = 9;

    // History buffer per channel. It is a power of two so that the
    // addresses wrap without extra logic.
    localparam int HIST_DEPTH = 128;
    localparam int HIST_ADDR_WIDTH = $clog2(HIST_DEPTH);

    // Guard bits on top of the product width for the 37 accumulations.
    localparam int ACC_GROWTH = 3;

    // Controller states.
    // IDLE waits for a strobe edge and also hosts the post-reset clear sweep.
    // LOAD writes the new samples and clears the accumulators.
    // MAC runs one folded tap per cycle.
    // FINISH hands the accumulators to the output stage.
    typedef enum logic [1:0] {
        IDLE,
        LOAD,
        MAC,
        FINISH
    } ctl_state_t;

    // Half-filter coefficient for tap index k, 0 to FIR_HALF.
    // Index FIR_HALF is the centre tap, which is used once.
    // Indices outside that range return zero.
    function automatic logic signed [COEFF_WIDTH-1:0] fir_coeff(input int k);
        `include "fir_coeff.svh"
    endfunction

endpackage

/* design/output_join.sv */
`timescale 1ns/1ps

module output_join import fir_pkg::*; #(
    parameter  int data_width = 9,
    localparam int mult_width = data_width + COEFF_WIDTH + 1,
    localparam int acc_width  = mult_width + ACC_GROWTH,
    localparam int out_width  = 2 * data_width + 2
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         finish,
    input  logic signed [acc_width-1:0]  left_acc,
    input  logic signed [acc_width-1:0]  right_acc,
    output logic signed [out_width-1:0]  left_out,
    output logic signed [out_width-1:0]  right_out,
    output logic                         sample_out
);

    // Wide enough to hold both the rounded accumulator and the output limits.
    localparam int sat_width = acc_width + out_width;

    localparam logic signed [sat_width-1:0] out_max =
        {{(sat_width - out_width + 1){1'b0}}, {(out_width - 1){1'b1}}};
    localparam logic signed [sat_width-1:0] out_min = -out_max - 1;

    // Round half up by dropping two bits, then clamp to the output range.
    function automatic logic signed [out_width-1:0] round_sat(
        input logic signed [acc_width-1:0] a
    );
        logic signed [acc_width:0]    biased;
        logic signed [acc_width-2:0]  shifted;
        logic signed [sat_width-1:0]  wide;
        biased  = a + 2;
        shifted = (acc_width - 1)'(biased >>> 2);
        wide    = shifted;
        if (wide > out_max) begin
            wide = out_max;
        end else if (wide < out_min) begin
            wide = out_min;
        end
        return out_width'(wide);
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            left_out   <= '0;
            right_out  <= '0;
            sample_out <= 1'b0;
        end else begin
            sample_out <= finish;
            if (finish) begin
                left_out  <= round_sat(left_acc);
                right_out <= round_sat(right_acc);
            end
        end
    end

endmodule

/* design/stereo_fir.sv */
`timescale 1ns/1ps

module stereo_fir import fir_pkg::*; #(
    parameter  int data_width = 9,
    localparam int out_width  = 2 * data_width + 2
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         sample,
    input  logic signed [data_width-1:0] left_in,
    input  logic signed [data_width-1:0] right_in,
    output logic signed [out_width-1:0]  left_out,
    output logic signed [out_width-1:0]  right_out,
    output logic                         sample_out
);

    localparam int acc_width = data_width + COEFF_WIDTH + 1 + ACC_GROWTH;

    logic                          load;
    logic                          clear;
    logic                          step;
    logic                          centre;
    logic                          finish;
    logic [HIST_ADDR_WIDTH-1:0]    wr_addr;
    logic [HIST_ADDR_WIDTH-1:0]    fwd_addr;
    logic [HIST_ADDR_WIDTH-1:0]    rev_addr;
    logic signed [COEFF_WIDTH-1:0] coeff;
    logic signed [acc_width-1:0]   left_acc;
    logic signed [acc_width-1:0]   right_acc;

    fir_control u_control (
        .clk      (clk),
        .rst      (rst),
        .sample   (sample),
        .load     (load),
        .clear    (clear),
        .step     (step),
        .centre   (centre),
        .finish   (finish),
        .wr_addr  (wr_addr),
        .fwd_addr (fwd_addr),
        .rev_addr (rev_addr),
        .coeff    (coeff)
    );

    // Both channels share every control signal and run in lockstep.
    fir_channel #(.data_width(data_width)) u_left (
        .clk       (clk),
        .rst       (rst),
        .load      (load),
        .clear     (clear),
        .step      (step),
        .centre    (centre),
        .wr_addr   (wr_addr),
        .fwd_addr  (fwd_addr),
        .rev_addr  (rev_addr),
        .coeff     (coeff),
        .sample_in (left_in),
        .acc       (left_acc)
    );

    fir_channel #(.data_width(data_width)) u_right (
        .clk       (clk),
        .rst       (rst),
        .load      (load),
        .clear     (clear),
        .step      (step),
        .centre    (centre),
        .wr_addr   (wr_addr),
        .fwd_addr  (fwd_addr),
        .rev_addr  (rev_addr),
        .coeff     (coeff),
        .sample_in (right_in),
        .acc       (right_acc)
    );

    output_join #(.data_width(data_width)) u_join (
        .clk        (clk),
        .rst        (rst),
        .finish     (finish),
        .left_acc   (left_acc),
        .right_acc  (right_acc),
        .left_out   (left_out),
        .right_out  (right_out),
        .sample_out (sample_out)
    );

endmodule

/* stereo_fir.f */
+incdir+design
design/fir_pkg.sv
design/fir_control.sv
design/fir_channel.sv
design/output_join.sv
design/stereo_fir.sv
test/stereo_fir_properties.sv
test/stereo_fir_tb.sv

/* test/fir_stim.txt */
# test hold left_in right_in left_out right_out
# Test and hold are decimal and hold counts cycles with sample high. Data are hex.
1 0 000 000 00000 00000
2 1 064 000 00000 00000
2 1 000 000 FFFE7 00000
2 1 000 000 FFFE7 00000
2 1 000 000 FFFCE 00000
2 1 000 000 FFFB5 00000
2 1 000 000 FFFB5 00000
2 1 000 000 FFF9C 00000
2 1 000 000 FFF9C 00000
3 1 028 1E2 FFFB5 00000
3 1 000 000 FFFDD 00008
3 1 000 000 0000F 00008
3 1 000 000 00037 0000F
4 6 000 010 00091 00017
4 3 000 000 000DC 00013
5 2 1EC 000 00104 0001A
5 2 000 000 00122 00016
6 1 100 0FF 00113 0000B
6 1 100 0FF 00121 FFFBC
6 1 100 0FF 000E4 FFF69
6 1 100 0FF 000B0 FFEDB
6 1 100 0FF 000BC FFE01
6 1 100 0FF 000A0 FFD34

/* test/stereo_fir_properties.sv */
`timescale 1ns/1ps

module stereo_fir_properties (
    input logic clk,
    input logic rst,
    input logic sample,
    input logic sample_out
);

    // Cycles from the first edge with sample high to the rise of sample_out.
    localparam int latency = 40;

    // The output valid is a single-cycle pulse.
    property single_pulse;
        @(posedge clk) disable iff (rst)
        sample_out |=> !sample_out;
    endproperty

    // The pulse is seen one edge after it is driven, so the strobe edge
    // lies latency + 1 edges back, with sample low one edge before that.
    property strobe_to_pulse;
        @(posedge clk) disable iff (rst)
        sample_out |-> ($past(sample, latency + 1) && !$past(sample, latency + 2));
    endproperty

    property quiet_in_reset;
        @(posedge clk)
        (rst && $past(rst)) |-> !sample_out;
    endproperty

    assert property (single_pulse)
        else $error("sample_out high for two consecutive cycles");

    assert property (strobe_to_pulse)
        else $error("sample_out not %0d cycles after a strobe edge", latency);

    assert property (quiet_in_reset)
        else $error("sample_out high during reset");

endmodule

bind stereo_fir stereo_fir_properties u_properties (
    .clk        (clk),
    .rst        (rst),
    .sample     (sample),
    .sample_out (sample_out)
);

/* test/stereo_fir_tb.sv */
`timescale 1ns/1ps

module stereo_fir_tb;

    localparam int data_width     = 9;
    localparam int out_width      = 2 * data_width + 2;
    localparam int timeout_cycles = 100;
    localparam int quiet_cycles   = 48;
    localparam int edge_test      = 4;
    localparam int busy_test      = 5;

    logic                         clk;
    logic                         rst;
    logic                         sample;
    logic signed [data_width-1:0] left_in;
    logic signed [data_width-1:0] right_in;
    logic signed [out_width-1:0]  left_out;
    logic signed [out_width-1:0]  right_out;
    logic                         sample_out;

    int          pass_count;
    int          fail_count;
    int          test_errors;
    int          test_records;
    logic        timed_out;
    logic [15:0] lfsr;

    stereo_fir #(.data_width(data_width)) DUT (
        .clk        (clk),
        .rst        (rst),
        .sample     (sample),
        .left_in    (left_in),
        .right_in   (right_in),
        .left_out   (left_out),
        .right_out  (right_out),
        .sample_out (sample_out)
    );

    always #20 clk = ~clk;

    // 16-bit Fibonacci LFSR with taps 16, 14, 13 and 11.
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // Idle gap of 0 to 15 cycles, one LFSR step for each of its 4 bits.
    task automatic draw_gap(output int gap);
        int i;
        gap = 0;
        for (i = 0; i < 4; i++) begin
            lfsr = lfsr_next(lfsr);
            gap  = (gap << 1) | int'(lfsr[0]);
        end
    endtask

    // Inputs change and outputs are read 2 ns after the rising edge.
    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic check_out(input string name, input logic [out_width-1:0] expected,
                             input logic [out_width-1:0] actual, input int test);
        if (actual !== expected) begin
            $display("[ERROR] test %0d: %s expected %h, got %h", test, name, expected, actual);
            fail_count++;
            test_errors++;
        end else begin
            pass_count++;
        end
    endtask

    task automatic watch_quiet(input int cycles, input int test);
        int i;
        for (i = 0; i < cycles; i++) begin
            next_cycle();
            if (sample_out) begin
                $display("test %0d: sample_out pulsed when no result was due", test);
                fail_count++;
                test_errors++;
            end
        end
    endtask

    task automatic wait_result(input int test, output logic seen);
        int cycles;
        cycles = 0;
        while (!sample_out && cycles < timeout_cycles) begin
            next_cycle();
            cycles++;
        end
        seen = sample_out;
        if (!seen) begin
            $display("test %0d: no sample_out within %0d cycles", test, timeout_cycles);
            fail_count++;
            test_errors++;
        end
    endtask

    // One record is one strobe, or with a hold of zero an idle check.
    task automatic apply_record(input int test, input int hold,
                                input logic [data_width-1:0] lin,
                                input logic [data_width-1:0] rin,
                                input logic [out_width-1:0] exp_l,
                                input logic [out_width-1:0] exp_r);
        logic seen;
        int   gap;
        seen = 1'b1;
        if (hold == 0) begin
            watch_quiet(quiet_cycles, test);
        end else begin
            left_in  = lin;
            right_in = rin;
            sample   = 1'b1;
            repeat (hold) next_cycle();
            if (test != edge_test) begin
                sample = 1'b0;
            end
            if (test == busy_test) begin
                // This edge lands in MAC. Its data must never reach the history.
                repeat (8) next_cycle();
                left_in  = ~lin;
                right_in = ~rin;
                sample   = 1'b1;
                repeat (2) next_cycle();
                sample = 1'b0;
            end
            wait_result(test, seen);
        end
        if (seen) begin
            check_out("left_out", exp_l, left_out, test);
            check_out("right_out", exp_r, right_out, test);
            if (hold != 0) begin
                draw_gap(gap);
                watch_quiet(quiet_cycles + gap, test);
            end
        end else begin
            timed_out = 1'b1;
        end
        // A held strobe stays high until the controller has long been back
        // in IDLE, so only a true edge can start a run.
        if (sample) begin
            sample = 1'b0;
            next_cycle();
        end
    endtask

    task automatic report_test(input int test);
        if (test_errors == 0) begin
            $display("test %0d finished: %0d records, no errors", test, test_records);
        end else begin
            $display("test %0d finished: %0d records, %0d errors", test, test_records,
                     test_errors);
        end
    endtask

    initial begin
        int                    fd;
        int                    got;
        int                    test;
        int                    hold;
        int                    cur_test;
        int                    total_records;
        logic [data_width-1:0] lin;
        logic [data_width-1:0] rin;
        logic [out_width-1:0]  exp_l;
        logic [out_width-1:0]  exp_r;
        string                 line;
        clk           = 1'b0;
        rst           = 1'b1;
        sample        = 1'b0;
        left_in       = '0;
        right_in      = '0;
        pass_count    = 0;
        fail_count    = 0;
        test_errors   = 0;
        test_records  = 0;
        total_records = 0;
        timed_out     = 1'b0;
        cur_test      = -1;
        lfsr          = 16'd51683;
        repeat (10) @(posedge clk);
        #2;
        rst = 1'b0;
        // The history clear sweep takes 128 cycles after reset.
        repeat (140) next_cycle();
        fd = $fopen("test/fir_stim.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file test/fir_stim.txt");
            fail_count++;
        end else begin
            while (!$feof(fd) && !timed_out) begin
                line = "";
                got  = $fgets(line, fd);
                got  = $sscanf(line, "%d %d %h %h %h %h", test, hold, lin, rin, exp_l, exp_r);
                if (got == 6) begin
                    if (test != cur_test) begin
                        if (cur_test >= 0) begin
                            report_test(cur_test);
                        end
                        cur_test     = test;
                        test_errors  = 0;
                        test_records = 0;
                    end
                    test_records++;
                    total_records++;
                    apply_record(test, hold, lin, rin, exp_l, exp_r);
                end
            end
            $fclose(fd);
            if (cur_test >= 0) begin
                report_test(cur_test);
            end
            if (total_records == 0) begin
                $display("the stimulus file held no records");
                fail_count++;
            end
        end
        $display("checks passed: %0d, checks failed: %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule
